/* logic/cmdq_cmd_pkg.sv */
// Command word format
package cmdq_cmd_pkg;

localparam int CMD_WIDTH = 32;

// scratch memory shape, fixed by the command fields
localparam int MEM_ADDR_WIDTH = 8;
localparam int MEM_DATA_WIDTH = 16;
localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;

localparam int COPY_LEN_WIDTH = 6;

localparam logic [1:0] OP_STORE = 2'b01;
localparam logic [1:0] OP_COPY = 2'b10;

// one command word, read as store or copy depending on the opcode
typedef union packed {
	struct packed {
		logic [1:0] opcode;
		logic [MEM_ADDR_WIDTH-1:0] addr;
		logic [5:0] unused;
		logic [MEM_DATA_WIDTH-1:0] data;
	} store;
	struct packed {
		logic [1:0] opcode;
		logic [MEM_ADDR_WIDTH-1:0] dst;
		logic [MEM_ADDR_WIDTH-1:0] src;
		logic [COPY_LEN_WIDTH-1:0] len;
		logic [7:0] unused;
	} copy;
} cmd_word_u;

endpackage

/* logic/cmdq_apb_pkg.sv */
// APB register map
package cmdq_apb_pkg;

// byte offsets of the registers
localparam logic [11:0] REG_CMD = 12'h000;
localparam logic [11:0] REG_STATUS = 12'h004;
localparam logic [11:0] REG_DONE = 12'h008;
localparam logic [11:0] REG_BAD = 12'h00C;

// scratch memory window, word index in paddr[9:2]
localparam logic [11:0] WIN_BASE = 12'h400;

// status register bits
localparam int ST_EMPTY = 0;
localparam int ST_FULL = 1;
localparam int ST_ALMOST_FULL = 2;
localparam int ST_IDLE = 3;

localparam int COUNT_WIDTH = 16;

endpackage

/* logic/block_ram.sv */
// Single port block RAM
`timescale 1ns/1ps

module block_ram #(
	parameter int ADDR_WIDTH = 8,
	parameter int DATA_WIDTH = 16,
	parameter int DEPTH = 256
) (
	input logic clk,
	input logic [ADDR_WIDTH-1:0] addr,
	input logic [DATA_WIDTH-1:0] i_data,
	input logic we,
	output logic [DATA_WIDTH-1:0] o_data
);

logic [DATA_WIDTH-1:0] mem [DEPTH];

// read returns the old word on a write cycle
always_ff @(posedge clk) begin
	if (we)
		mem[addr] <= i_data;
	o_data <= mem[addr];
end

endmodule

/* logic/cmd_fifo.sv */
// Command queue FIFO
`timescale 1ns/1ps

module cmd_fifo #(
	parameter int DATA_WIDTH = 32,
	parameter int FIFO_DEPTH = 16,
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input logic clk,
	input logic reset,

	// write side
	input logic [DATA_WIDTH-1:0] wdata,
	input logic write_valid,
	output logic write_ready,

	// read side
	output logic [DATA_WIDTH-1:0] rdata,
	output logic read_valid,
	input logic read_ready,

	// flags
	output logic almost_full,
	output logic full,
	output logic empty
);

logic [FIFO_ADDR_WIDTH-1:0] write_ptr;
logic [FIFO_ADDR_WIDTH-1:0] read_ptr;
logic [FIFO_ADDR_WIDTH-1:0] write_ptr_next;
logic [FIFO_ADDR_WIDTH-1:0] read_ptr_next;
logic [FIFO_ADDR_WIDTH-1:0] ram_addr;
logic write_xfer;
logic read_xfer;
logic both_xfer;
logic has_data;
logic is_full;

block_ram #(
	.ADDR_WIDTH(FIFO_ADDR_WIDTH),
	.DATA_WIDTH(DATA_WIDTH),
	.DEPTH(FIFO_DEPTH)
) ram (
	.clk(clk),
	.addr(ram_addr),
	.i_data(wdata),
	.we(write_xfer),
	.o_data(rdata)
);

assign write_ready = write_valid && !is_full;
assign write_xfer = write_valid && write_ready;
assign read_xfer = read_valid && read_ready;
assign both_xfer = write_xfer && read_xfer;

// a write takes the single port, otherwise it keeps reading the head
assign ram_addr = write_xfer ? write_ptr : read_ptr;

// circular pointers
assign write_ptr_next = (write_ptr == FIFO_DEPTH - 1) ? '0 : write_ptr + 1'b1;
assign read_ptr_next = (read_ptr == FIFO_DEPTH - 1) ? '0 : read_ptr + 1'b1;

assign almost_full = (write_ptr_next == read_ptr);
assign full = is_full;
assign empty = !has_data;

always_ff @(posedge clk) begin
	if (reset) begin
		write_ptr <= '0;
		read_ptr <= '0;
		has_data <= 1'b0;
		is_full <= 1'b0;
	end else begin
		if (write_xfer) begin
			write_ptr <= write_ptr_next;
			has_data <= 1'b1;
			if (almost_full)
				is_full <= 1'b1;
		end

		// a pop frees a slot, so it overrides the full set above
		if (read_xfer) begin
			read_ptr <= read_ptr_next;
			is_full <= 1'b0;
			if (read_ptr_next == write_ptr && !both_xfer)
				has_data <= 1'b0;
		end
	end
end

// head word is valid one cycle after the port was free to read it
always_ff @(posedge clk) begin
	if (reset) begin
		read_valid <= 1'b0;
	end else begin
		if (has_data && !read_valid && !write_xfer)
			read_valid <= 1'b1;

		// ram output gets replaced on a write, so drop valid
		if (read_xfer || write_xfer)
			read_valid <= 1'b0;
	end
end

endmodule

/* logic/apb_regs.sv */
// APB registers and memory window
`timescale 1ns/1ps

module apb_regs import cmdq_cmd_pkg::*, cmdq_apb_pkg::*; (
	input logic clk,
	input logic reset,

	// apb slave
	input logic [11:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,

	// command queue
	output logic [CMD_WIDTH-1:0] wdata,
	output logic write_valid,
	input logic write_ready,
	input logic empty,
	input logic full,
	input logic almost_full,

	// executor
	input logic exec_idle,
	input logic cmd_done,
	input logic cmd_bad,

	// scratch memory window
	output logic req,
	output logic we,
	output logic [MEM_ADDR_WIDTH-1:0] addr,
	output logic [MEM_DATA_WIDTH-1:0] mem_wdata,
	input logic gnt,
	input logic [MEM_DATA_WIDTH-1:0] mem_rdata
);

logic access;
logic hit_cmd;
logic hit_status;
logic hit_done;
logic hit_bad;
logic hit_win;
logic bad_access;
logic win_rd_wait;
logic [COUNT_WIDTH-1:0] done_count;
logic [COUNT_WIDTH-1:0] bad_count;

assign access = psel && penable;

assign hit_cmd = (paddr == REG_CMD);
assign hit_status = (paddr == REG_STATUS);
assign hit_done = (paddr == REG_DONE);
assign hit_bad = (paddr == REG_BAD);
assign hit_win = (paddr[11:10] == WIN_BASE[11:10]);

// unmapped offset, or a write to one of the read-only registers
assign bad_access = !(hit_cmd || hit_status || hit_done || hit_bad || hit_win) ||
	(pwrite && (hit_status || hit_done || hit_bad));

// command push, held until the queue takes it
assign wdata = pwdata;
assign write_valid = access && pwrite && hit_cmd;

// window request drops while waiting for read data
assign req = access && hit_win && !win_rd_wait;
assign we = pwrite;
assign addr = paddr[MEM_ADDR_WIDTH+1:2];
assign mem_wdata = pwdata[MEM_DATA_WIDTH-1:0];

always_comb begin
	pready = 1'b0;
	if (access) begin
		if (bad_access)
			pready = 1'b1;
		else if (hit_cmd)
			pready = pwrite ? write_ready : 1'b1;
		else if (hit_win)
			pready = pwrite ? gnt : win_rd_wait;
		else
			pready = 1'b1;
	end
end

assign pslverr = access && bad_access;

always_comb begin
	prdata = '0;
	if (hit_status) begin
		prdata[ST_EMPTY] = empty;
		prdata[ST_FULL] = full;
		prdata[ST_ALMOST_FULL] = almost_full;
		prdata[ST_IDLE] = empty && exec_idle;
	end else if (hit_done) begin
		prdata[COUNT_WIDTH-1:0] = done_count;
	end else if (hit_bad) begin
		prdata[COUNT_WIDTH-1:0] = bad_count;
	end else if (hit_win) begin
		prdata[MEM_DATA_WIDTH-1:0] = mem_rdata;
	end
end

// window read waits one cycle after its grant
always_ff @(posedge clk) begin
	if (reset)
		win_rd_wait <= 1'b0;
	else if (win_rd_wait)
		win_rd_wait <= 1'b0;
	else if (req && gnt && !pwrite)
		win_rd_wait <= 1'b1;
end

always_ff @(posedge clk) begin
	if (reset) begin
		done_count <= '0;
		bad_count <= '0;
	end else begin
		if (cmd_done)
			done_count <= done_count + 1'b1;
		if (cmd_bad)
			bad_count <= bad_count + 1'b1;
	end
end

endmodule

/* logic/mem_arbiter.sv */
// Round robin scratch memory arbiter
`timescale 1ns/1ps

module mem_arbiter import cmdq_cmd_pkg::*; (
	input logic clk,
	input logic reset,

	// requester a
	input logic req_a,
	input logic we_a,
	input logic [MEM_ADDR_WIDTH-1:0] addr_a,
	input logic [MEM_DATA_WIDTH-1:0] wdata_a,
	output logic gnt_a,

	// requester b
	input logic req_b,
	input logic we_b,
	input logic [MEM_ADDR_WIDTH-1:0] addr_b,
	input logic [MEM_DATA_WIDTH-1:0] wdata_b,
	output logic gnt_b,

	// shared read data, valid the cycle after a granted read
	output logic [MEM_DATA_WIDTH-1:0] rdata,

	// ram side
	output logic [MEM_ADDR_WIDTH-1:0] ram_addr,
	output logic [MEM_DATA_WIDTH-1:0] ram_wdata,
	output logic ram_we,
	input logic [MEM_DATA_WIDTH-1:0] ram_rdata
);

// set when b took the last grant
logic last_b;

// on a tie the requester that lost last time wins
assign gnt_a = req_a && (!req_b || last_b);
assign gnt_b = req_b && !gnt_a;

assign ram_addr = gnt_b ? addr_b : addr_a;
assign ram_wdata = gnt_b ? wdata_b : wdata_a;
assign ram_we = (gnt_a && we_a) || (gnt_b && we_b);
assign rdata = ram_rdata;

always_ff @(posedge clk) begin
	if (reset)
		last_b <= 1'b0;
	else if (gnt_a)
		last_b <= 1'b0;
	else if (gnt_b)
		last_b <= 1'b1;
end

endmodule

/* logic/cmd_executor.sv */
// Command executor
`timescale 1ns/1ps

module cmd_executor import cmdq_cmd_pkg::*; (
	input logic clk,
	input logic reset,

	// command queue head
	input cmd_word_u cmd,
	input logic read_valid,
	output logic read_ready,

	// scratch memory requester
	output logic req,
	output logic we,
	output logic [MEM_ADDR_WIDTH-1:0] addr,
	output logic [MEM_DATA_WIDTH-1:0] wdata,
	input logic gnt,
	input logic [MEM_DATA_WIDTH-1:0] mem_rdata,

	// status
	output logic idle,
	output logic cmd_done,
	output logic cmd_bad
);

localparam logic [1:0] S_IDLE = 2'd0;
localparam logic [1:0] S_READ = 2'd1;
localparam logic [1:0] S_LATCH = 2'd2;
localparam logic [1:0] S_WRITE = 2'd3;

logic [1:0] state;
logic pop;
logic [MEM_ADDR_WIDTH-1:0] src_addr;
logic [MEM_ADDR_WIDTH-1:0] dst_addr;
logic [COPY_LEN_WIDTH-1:0] remain;
logic [MEM_DATA_WIDTH-1:0] data_word;

// a command is taken off the queue only when the previous one is finished
assign idle = (state == S_IDLE);
assign read_ready = idle;
assign pop = read_valid && read_ready;

assign req = (state == S_READ) || (state == S_WRITE);
assign we = (state == S_WRITE);
assign addr = (state == S_READ) ? src_addr : dst_addr;
assign wdata = data_word;

always_ff @(posedge clk) begin
	if (reset) begin
		state <= S_IDLE;
		cmd_done <= 1'b0;
		cmd_bad <= 1'b0;
	end else begin
		cmd_done <= 1'b0;
		cmd_bad <= 1'b0;
		case (state)
			S_IDLE: begin
				if (pop) begin
					if (cmd.store.opcode == OP_STORE)
						state <= S_WRITE;
					else if (cmd.copy.opcode != OP_COPY)
						cmd_bad <= 1'b1;
					else if (cmd.copy.len == '0)
						cmd_done <= 1'b1;
					else
						state <= S_READ;
				end
			end
			S_READ: begin
				if (gnt)
					state <= S_LATCH;
			end
			S_LATCH: begin
				state <= S_WRITE;
			end
			default: begin
				// last word written ends the command
				if (gnt) begin
					if (remain == 1) begin
						state <= S_IDLE;
						cmd_done <= 1'b1;
					end else begin
						state <= S_READ;
					end
				end
			end
		endcase
	end
end

// store runs as a one word pass through the write state
always_ff @(posedge clk) begin
	if (pop) begin
		if (cmd.copy.opcode == OP_COPY) begin
			dst_addr <= cmd.copy.dst;
			src_addr <= cmd.copy.src;
			remain <= cmd.copy.len;
		end else begin
			dst_addr <= cmd.store.addr;
			data_word <= cmd.store.data;
			remain <= 1;
		end
	end
	if (state == S_LATCH)
		data_word <= mem_rdata;
	// ascending order, so an overlapping copy reads already copied words
	if (state == S_WRITE && gnt) begin
		dst_addr <= dst_addr + 1'b1;
		src_addr <= src_addr + 1'b1;
		remain <= remain - 1'b1;
	end
end

endmodule

/* logic/cmdq_top.sv */
// Memory command queue top
`timescale 1ns/1ps

module cmdq_top import cmdq_cmd_pkg::*; #(
	parameter int FIFO_DEPTH = 16,
	parameter int FIFO_ADDR_WIDTH = 4
) (
	input logic clk,
	input logic reset,

	// apb slave
	input logic [11:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

// queue
logic [CMD_WIDTH-1:0] cmd_wdata;
logic cmd_write_valid;
logic cmd_write_ready;
logic [CMD_WIDTH-1:0] cmd_rdata;
logic cmd_read_valid;
logic cmd_read_ready;
logic fifo_almost_full;
logic fifo_full;
logic fifo_empty;

// executor, arbiter port a
logic exec_req;
logic exec_we;
logic [MEM_ADDR_WIDTH-1:0] exec_addr;
logic [MEM_DATA_WIDTH-1:0] exec_wdata;
logic exec_gnt;
logic exec_idle;
logic cmd_done;
logic cmd_bad;

// host window, arbiter port b
logic win_req;
logic win_we;
logic [MEM_ADDR_WIDTH-1:0] win_addr;
logic [MEM_DATA_WIDTH-1:0] win_wdata;
logic win_gnt;

// scratch ram
logic [MEM_DATA_WIDTH-1:0] mem_rdata;
logic [MEM_ADDR_WIDTH-1:0] ram_addr;
logic [MEM_DATA_WIDTH-1:0] ram_wdata;
logic ram_we;
logic [MEM_DATA_WIDTH-1:0] ram_rdata;

cmd_fifo #(
	.DATA_WIDTH(CMD_WIDTH),
	.FIFO_DEPTH(FIFO_DEPTH),
	.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
) fifo0 (
	.clk(clk),
	.reset(reset),
	.wdata(cmd_wdata),
	.write_valid(cmd_write_valid),
	.write_ready(cmd_write_ready),
	.rdata(cmd_rdata),
	.read_valid(cmd_read_valid),
	.read_ready(cmd_read_ready),
	.almost_full(fifo_almost_full),
	.full(fifo_full),
	.empty(fifo_empty)
);

apb_regs regs0 (
	.clk(clk),
	.reset(reset),
	.paddr(paddr),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.pwdata(pwdata),
	.prdata(prdata),
	.pready(pready),
	.pslverr(pslverr),
	.wdata(cmd_wdata),
	.write_valid(cmd_write_valid),
	.write_ready(cmd_write_ready),
	.empty(fifo_empty),
	.full(fifo_full),
	.almost_full(fifo_almost_full),
	.exec_idle(exec_idle),
	.cmd_done(cmd_done),
	.cmd_bad(cmd_bad),
	.req(win_req),
	.we(win_we),
	.addr(win_addr),
	.mem_wdata(win_wdata),
	.gnt(win_gnt),
	.mem_rdata(mem_rdata)
);

cmd_executor exec0 (
	.clk(clk),
	.reset(reset),
	.cmd(cmd_rdata),
	.read_valid(cmd_read_valid),
	.read_ready(cmd_read_ready),
	.req(exec_req),
	.we(exec_we),
	.addr(exec_addr),
	.wdata(exec_wdata),
	.gnt(exec_gnt),
	.mem_rdata(mem_rdata),
	.idle(exec_idle),
	.cmd_done(cmd_done),
	.cmd_bad(cmd_bad)
);

mem_arbiter arb0 (
	.clk(clk),
	.reset(reset),
	.req_a(exec_req),
	.we_a(exec_we),
	.addr_a(exec_addr),
	.wdata_a(exec_wdata),
	.gnt_a(exec_gnt),
	.req_b(win_req),
	.we_b(win_we),
	.addr_b(win_addr),
	.wdata_b(win_wdata),
	.gnt_b(win_gnt),
	.rdata(mem_rdata),
	.ram_addr(ram_addr),
	.ram_wdata(ram_wdata),
	.ram_we(ram_we),
	.ram_rdata(ram_rdata)
);

block_ram #(
	.ADDR_WIDTH(MEM_ADDR_WIDTH),
	.DATA_WIDTH(MEM_DATA_WIDTH),
	.DEPTH(MEM_DEPTH)
) scratch0 (
	.clk(clk),
	.addr(ram_addr),
	.i_data(ram_wdata),
	.we(ram_we),
	.o_data(ram_rdata)
);

endmodule

/* tests/cmdq_sva.sv */
// Command queue assertions
`timescale 1ns/1ps

module cmdq_sva #(
	parameter int DATA_WIDTH = 32
) (
	input logic clk,
	input logic reset,
	input logic [DATA_WIDTH-1:0] rdata,
	input logic read_valid,
	input logic read_ready,
	input logic full,
	input logic empty
);

// failures seen so far, read by the testbench report
int assert_errors = 0;

no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
	(read_valid && read_ready) |-> !empty)
	else begin
		$error("queue popped while empty");
		assert_errors++;
	end

never_full_and_empty: assert property (@(posedge clk) disable iff (reset)
	!(full && empty))
	else begin
		$error("queue flags show full and empty together");
		assert_errors++;
	end

// head word held while the consumer stalls
rdata_stable: assert property (@(posedge clk) disable iff (reset)
	(read_valid && !read_ready) ##1 read_valid |-> $stable(rdata))
	else begin
		$error("queue head word changed while read_valid was held");
		assert_errors++;
	end

endmodule

bind cmd_fifo cmdq_sva #(.DATA_WIDTH(DATA_WIDTH)) sva0 (
	.clk(clk),
	.reset(reset),
	.rdata(rdata),
	.read_valid(read_valid),
	.read_ready(read_ready),
	.full(full),
	.empty(empty)
);

/* tests/cmdq_tb.sv */
// Command queue testbench
`timescale 1ns/1ps

module cmdq_tb import cmdq_cmd_pkg::*, cmdq_apb_pkg::*; ();

localparam int CLK_PERIOD = 100;
localparam int N_STORE = 24;
localparam int N_COPY = 20;
localparam int N_PRESSURE = 40;
localparam int N_BADOP = 4;
localparam int N_CMDS = N_STORE + N_COPY + N_PRESSURE + N_BADOP;
// window traffic of the sweeps and polls comes on top of the command time
localparam int MARGIN_CYCLES = 16000;
localparam int TIMEOUT_CYCLES = N_CMDS * 64 * 4 + MARGIN_CYCLES;

logic clk = 1'b0;
logic reset;
logic [11:0] paddr;
logic psel;
logic penable;
logic pwrite;
logic [31:0] pwdata;
logic [31:0] prdata;
logic pready;
logic pslverr;

logic [MEM_DATA_WIDTH-1:0] model [MEM_DEPTH];
logic [COUNT_WIDTH-1:0] exp_done = '0;
logic [COUNT_WIDTH-1:0] exp_bad = '0;
logic [15:0] lfsr_state = 16'd43;
int err_word = 0;
int err_count = 0;
int err_status = 0;
int err_resp = 0;
int err_other = 0;

// observed window words waiting for the comparing process
logic [MEM_ADDR_WIDTH-1:0] obs_addr_q [$];
logic [31:0] obs_data_q [$];
logic [MEM_DATA_WIDTH-1:0] obs_exp_q [$];
event word_seen;

cmdq_top #(
	.FIFO_DEPTH(16),
	.FIFO_ADDR_WIDTH(4)
) dut0 (
	.clk(clk),
	.reset(reset),
	.paddr(paddr),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.pwdata(pwdata),
	.prdata(prdata),
	.pready(pready),
	.pslverr(pslverr)
);

always #(CLK_PERIOD / 2) clk = ~clk;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic next_random_bit();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

function automatic logic [31:0] random_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[30:0], next_random_bit()};
	return v;
endfunction

// applies one command to the model and returns 0 for an unknown opcode
function automatic logic apply_cmd(input cmd_word_u c);
	logic [MEM_ADDR_WIDTH-1:0] s;
	logic [MEM_ADDR_WIDTH-1:0] d;
	if (c.store.opcode == OP_STORE) begin
		model[c.store.addr] = c.store.data;
		return 1'b1;
	end
	if (c.copy.opcode != OP_COPY)
		return 1'b0;
	s = c.copy.src;
	d = c.copy.dst;
	// ascending word by word so overlaps see words already copied
	for (int i = 0; i < c.copy.len; i++) begin
		model[d] = model[s];
		s = s + 1'b1;
		d = d + 1'b1;
	end
	return 1'b1;
endfunction

task automatic check_word(input logic [MEM_DATA_WIDTH-1:0] got,
		input logic [MEM_DATA_WIDTH-1:0] want, input string what);
	if (got !== want) begin
		$display("[FAIL] %0t %s: got %h expected %h", $time, what, got, want);
		err_word++;
	end
endtask

task automatic check_count(input logic [COUNT_WIDTH-1:0] got,
		input logic [COUNT_WIDTH-1:0] want, input string what);
	if (got !== want) begin
		$display("[FAIL] %0t %s: got %0d expected %0d", $time, what, got, want);
		err_count++;
	end
endtask

task automatic check_status(input logic [ST_IDLE:0] got, input logic [ST_IDLE:0] want,
		input string what);
	if (got !== want) begin
		$display("[FAIL] %0t %s: got %b expected %b", $time, what, got, want);
		err_status++;
	end
endtask

task automatic check_resp(input logic got, input logic want, input string what);
	if (got !== want) begin
		$display("[FAIL] %0t %s: pslverr %b expected %b", $time, what, got, want);
		err_resp++;
	end
endtask

// one APB transfer driven on falling edges
task automatic apb_access(input logic [11:0] a, input logic wr, input logic [31:0] wd,
		output logic [31:0] rd, output logic err);
	@(negedge clk);
	paddr = a;
	pwrite = wr;
	pwdata = wd;
	psel = 1'b1;
	penable = 1'b0;
	@(negedge clk);
	penable = 1'b1;
	#1;
	while (!pready) begin
		@(negedge clk);
		#1;
	end
	rd = prdata;
	err = pslverr;
	@(negedge clk);
	psel = 1'b0;
	penable = 1'b0;
endtask

task automatic push_cmd(input cmd_word_u c);
	logic [31:0] rd;
	logic err;
	apb_access(REG_CMD, 1'b1, c, rd, err);
	check_resp(err, 1'b0, "command push");
	if (apply_cmd(c))
		exp_done++;
	else
		exp_bad++;
endtask

task automatic write_window(input logic [MEM_ADDR_WIDTH-1:0] a, input logic [31:0] wd);
	logic [31:0] rd;
	logic err;
	apb_access(WIN_BASE | {2'b00, a, 2'b00}, 1'b1, wd, rd, err);
	check_resp(err, 1'b0, "window write");
	model[a] = wd[MEM_DATA_WIDTH-1:0];
endtask

task automatic read_window(input logic [MEM_ADDR_WIDTH-1:0] a);
	logic [31:0] rd;
	logic err;
	apb_access(WIN_BASE | {2'b00, a, 2'b00}, 1'b0, '0, rd, err);
	check_resp(err, 1'b0, "window read");
	obs_addr_q.push_back(a);
	obs_data_q.push_back(rd);
	obs_exp_q.push_back(model[a]);
	-> word_seen;
endtask

task automatic sweep_memory();
	for (int i = 0; i < MEM_DEPTH; i++)
		read_window(MEM_ADDR_WIDTH'(i));
endtask

task automatic wait_idle();
	logic [31:0] rd;
	logic err;
	rd = '0;
	while (!rd[ST_IDLE]) begin
		apb_access(REG_STATUS, 1'b0, '0, rd, err);
		check_resp(err, 1'b0, "status poll");
	end
endtask

task automatic check_counters();
	logic [31:0] rd;
	logic err;
	apb_access(REG_DONE, 1'b0, '0, rd, err);
	check_resp(err, 1'b0, "DONE read");
	check_count(rd[COUNT_WIDTH-1:0], exp_done, "DONE counter");
	apb_access(REG_BAD, 1'b0, '0, rd, err);
	check_resp(err, 1'b0, "BAD read");
	check_count(rd[COUNT_WIDTH-1:0], exp_bad, "BAD counter");
endtask

task automatic check_idle_status(input string what);
	logic [31:0] rd;
	logic err;
	logic [ST_IDLE:0] want;
	want = '0;
	want[ST_EMPTY] = 1'b1;
	want[ST_IDLE] = 1'b1;
	apb_access(REG_STATUS, 1'b0, '0, rd, err);
	check_resp(err, 1'b0, what);
	check_status(rd[ST_IDLE:0], want, what);
endtask

task automatic expect_error(input logic [11:0] a, input logic wr, input string what);
	logic [31:0] rd;
	logic err;
	apb_access(a, wr, 32'hffff_ffff, rd, err);
	check_resp(err, 1'b1, what);
endtask

initial begin : compare_words
	logic [MEM_ADDR_WIDTH-1:0] a;
	logic [31:0] got;
	logic [MEM_DATA_WIDTH-1:0] want;
	forever begin
		@(word_seen);
		while (obs_addr_q.size() != 0) begin
			a = obs_addr_q.pop_front();
			got = obs_data_q.pop_front();
			want = obs_exp_q.pop_front();
			check_word(got[MEM_DATA_WIDTH-1:0], want, $sformatf("window word %02h", a));
			check_word(got[31:MEM_DATA_WIDTH], '0, $sformatf("upper bits of word %02h", a));
		end
	end
end

initial begin : watchdog
	#(TIMEOUT_CYCLES * CLK_PERIOD);
	$display("timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
	$display("Verification failed");
	$finish;
end

initial begin : main_sequence
	logic [31:0] rd;
	logic err;
	logic saw_full;
	logic saw_almost_full;
	cmd_word_u c;
	int total;
	paddr = '0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	pwdata = '0;
	reset = 1'b1;
	repeat (4) @(negedge clk);
	reset = 1'b0;

	check_idle_status("status after reset");
	check_counters();

	// fill the whole scratch memory with random upper bits that must read back as zero
	for (int i = 0; i < MEM_DEPTH; i++)
		write_window(MEM_ADDR_WIDTH'(i), random_bits(32));
	sweep_memory();

	for (int i = 0; i < N_STORE; i++) begin
		c = '0;
		c.store.opcode = OP_STORE;
		c.store.addr = MEM_ADDR_WIDTH'(random_bits(MEM_ADDR_WIDTH));
		c.store.data = MEM_DATA_WIDTH'(random_bits(MEM_DATA_WIDTH));
		push_cmd(c);
	end
	wait_idle();
	check_counters();
	sweep_memory();

	// forward overlap first and an empty copy second
	for (int i = 0; i < N_COPY; i++) begin
		c = '0;
		c.copy.opcode = OP_COPY;
		c.copy.src = MEM_ADDR_WIDTH'(random_bits(MEM_ADDR_WIDTH));
		c.copy.dst = MEM_ADDR_WIDTH'(random_bits(MEM_ADDR_WIDTH));
		c.copy.len = COPY_LEN_WIDTH'(random_bits(COPY_LEN_WIDTH));
		if (i == 0) begin
			c.copy.dst = c.copy.src + 8'd3;
			c.copy.len = 6'd20;
		end else if (i == 1) begin
			c.copy.len = '0;
		end
		push_cmd(c);
	end
	wait_idle();
	check_counters();
	sweep_memory();

	// long copies stay in the lower half while window reads use the upper half
	saw_full = 1'b0;
	saw_almost_full = 1'b0;
	for (int i = 0; i < N_PRESSURE; i++) begin
		c = '0;
		c.copy.opcode = OP_COPY;
		c.copy.dst = MEM_ADDR_WIDTH'(random_bits(6));
		c.copy.src = MEM_ADDR_WIDTH'(random_bits(6));
		c.copy.len = COPY_LEN_WIDTH'(32 + random_bits(5));
		push_cmd(c);
		apb_access(REG_STATUS, 1'b0, '0, rd, err);
		check_resp(err, 1'b0, "status read under load");
		if (rd[ST_FULL])
			saw_full = 1'b1;
		if (rd[ST_ALMOST_FULL])
			saw_almost_full = 1'b1;
		read_window(MEM_ADDR_WIDTH'(8'h80 | random_bits(7)));
	end
	if (!saw_full) begin
		$display("queue was never seen full while pushing long copies");
		err_other++;
	end
	if (!saw_almost_full) begin
		$display("queue was never seen almost full while pushing long copies");
		err_other++;
	end
	wait_idle();
	check_counters();
	sweep_memory();

	// opcodes 00 and 11 are counted as bad and leave the memory alone
	for (int i = 0; i < N_BADOP; i++) begin
		c = random_bits(32);
		c.store.opcode = (i % 2 == 0) ? 2'b00 : 2'b11;
		push_cmd(c);
	end
	wait_idle();
	check_counters();
	sweep_memory();

	expect_error(12'h010, 1'b0, "read of unmapped offset");
	expect_error(12'h3fc, 1'b1, "write to unmapped offset");
	expect_error(REG_STATUS, 1'b1, "write to STATUS");
	expect_error(REG_DONE, 1'b1, "write to DONE");
	check_idle_status("status after error responses");
	check_counters();

	repeat (2) @(posedge clk);
	total = err_word + err_count + err_status + err_resp + err_other +
		dut0.fifo0.sva0.assert_errors;
	$display("errors: word %0d, count %0d, status %0d, response %0d, other %0d, assertion %0d",
		err_word, err_count, err_status, err_resp, err_other, dut0.fifo0.sva0.assert_errors);
	if (total == 0)
		$display("Verification passed");
	else
		$display("Verification failed");
	$finish;
end

endmodule

/* vlog.f */
logic/cmdq_cmd_pkg.sv
logic/cmdq_apb_pkg.sv
logic/block_ram.sv
logic/cmd_fifo.sv
logic/apb_regs.sv
logic/mem_arbiter.sv
logic/cmd_executor.sv
logic/cmdq_top.sv
tests/cmdq_sva.sv
tests/cmdq_tb.sv
